//--- Makefile
# Verilator build and regression run for the register file subsystem

TOP := tb_rf_subsys
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "^Regression passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- common/rf_pkg.sv
// Register file widths, depth, request structs and power sequencer states
`default_nettype none

package rf_pkg;

    // ------------------------------
    // Geometry
    // ------------------------------

    // Number of entries in the array
    localparam int RF_DEPTH  = 16;

    // Address width needed to select one entry
    localparam int RF_ADDR_W = 4;

    // Data width seen by the user of the register file
    localparam int RF_DATA_W = 35;

    // Physical width of the array macro; the top bit is spare and written as zero
    localparam int RF_PHYS_W = 36;

    // ------------------------------
    // Request bundles
    // ------------------------------

    // Write request, sampled on wclk
    typedef struct packed {
        logic                 en;
        logic [RF_ADDR_W-1:0] addr;
        logic [RF_DATA_W-1:0] data;
    } rf_wr_req_t;

    // Read request, sampled on rclk
    typedef struct packed {
        logic                 en;
        logic [RF_ADDR_W-1:0] addr;
    } rf_rd_req_t;

    // Power sequencer states, walked in order from ON through OFF and back
    typedef enum logic [2:0] {
        ON         = 3'd0,
        ISOLATE    = 3'd1,
        POWER_DOWN = 3'd2,
        OFF        = 3'd3,
        POWER_UP   = 3'd4,
        DEISOLATE  = 3'd5
    } rf_pwr_state_t;

endpackage

`default_nettype wire

//--- filelist.f
common/rf_pkg.sv
hw/rf_reset_sync.sv
rf_macro/rf_array_2p.sv
rf_macro/rf_pg_16x35.sv
hw/rf_power_ctrl.sv
hw/rf_subsys_top.sv
tests/rf_subsys_properties.sv
tests/tb_rf_subsys.sv

//--- hw/rf_power_ctrl.sv
// Sleep and wake sequencer driving array isolation and the power enable chain
`timescale 1ns/10ps
`default_nettype none

module rf_power_ctrl #(
     parameter int PG_DELAY = 4
) (
     input  logic rclk
    ,input  logic rst_n
    ,input  logic sleep_req
    ,input  logic pwr_enable_b_out
    ,output logic isol_en
    ,output logic pwr_enable_b
    ,output logic rf_ready
);

    import rf_pkg::*;

    // Counter wide enough for PG_DELAY-1, never narrower than one bit
    localparam int CNT_W = (PG_DELAY > 1) ? $clog2(PG_DELAY) : 1;

    rf_pwr_state_t    state;
    logic [CNT_W-1:0] pg_cnt;

    // ------------------------------
    // Sequencer
    // ------------------------------

    // All outputs are registered so the array sees clean levels
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ON;
            pg_cnt       <= '0;
            isol_en      <= 1'b0;
            pwr_enable_b <= 1'b0;
            rf_ready     <= 1'b1;
        end else begin
            case (state)
                // Clamp outputs first and stop advertising readiness
                ON: begin
                    if (sleep_req) begin
                        isol_en  <= 1'b1;
                        rf_ready <= 1'b0;
                        pg_cnt   <= '0;
                        state    <= ISOLATE;
                    end
                end
                // Let isolation settle for PG_DELAY edges before cutting power
                ISOLATE: begin
                    if (pg_cnt == CNT_W'(PG_DELAY - 1)) begin
                        pwr_enable_b <= 1'b1;
                        state        <= POWER_DOWN;
                    end else begin
                        pg_cnt <= pg_cnt + 1'b1;
                    end
                end
                // The switch chain reports back once every segment is off
                POWER_DOWN: begin
                    if (pwr_enable_b_out) begin
                        state <= OFF;
                    end
                end
                OFF: begin
                    if (!sleep_req) begin
                        pwr_enable_b <= 1'b0;
                        state        <= POWER_UP;
                    end
                end
                // Isolation is held until the whole chain is back on
                POWER_UP: begin
                    if (!pwr_enable_b_out) begin
                        isol_en <= 1'b0;
                        state   <= DEISOLATE;
                    end
                end
                // One spare cycle with outputs live before accepting traffic
                DEISOLATE: begin
                    rf_ready <= 1'b1;
                    state    <= ON;
                end
                default: begin
                    state <= ON;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/rf_reset_sync.sv
// Two-flop active-low reset synchronizer with scan reset bypass
`timescale 1ns/10ps
`default_nettype none

module rf_reset_sync (
     input  logic clk
    ,input  logic rst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // Two stage chain, the second stage is the synchronized reset
    logic [1:0] sync_q;

    // Assertion is immediate through the async clear,
    // release walks a one through both flops on clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // In scan mode the tester owns the reset directly
    // so the flops cannot hold the logic in reset during shift
    always_comb begin
        if (fscan_rstbypen) begin
            rst_n_sync = fscan_byprst_b;
        end else begin
            rst_n_sync = sync_q[1];
        end
    end

endmodule

`default_nettype wire

//--- hw/rf_subsys_top.sv
// Top level of the power-gated register file subsystem
`timescale 1ns/10ps
`default_nettype none

module rf_subsys_top #(
     parameter int PG_DELAY   = 4
    ,parameter int ECHO_DELAY = 2
) (
     input  logic                         wclk
    ,input  logic                         rclk
    ,input  logic                         rst_n

    ,input  rf_pkg::rf_wr_req_t           wr
    ,input  rf_pkg::rf_rd_req_t           rd
    ,output logic [rf_pkg::RF_DATA_W-1:0] rdata

    ,input  logic                         sleep_req
    ,output logic                         rf_ready

    ,input  logic                         fscan_rstbypen
    ,input  logic                         fscan_byprst_b
);

    logic wrst_n_sync;
    logic rrst_n_sync;
    logic isol_en;
    logic pwr_enable_b;
    logic pwr_enable_b_out;

    // ------------------------------
    // Per-domain resets
    // ------------------------------

    rf_reset_sync u_wrst_sync (
         .clk            (wclk)
        ,.rst_n          (rst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (wrst_n_sync)
    );

    rf_reset_sync u_rrst_sync (
         .clk            (rclk)
        ,.rst_n          (rst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (rrst_n_sync)
    );

    // Sequencer lives in the read domain, same as the echo chain
    rf_power_ctrl #(
         .PG_DELAY (PG_DELAY)
    ) u_pwr_ctrl (
         .rclk             (rclk)
        ,.rst_n            (rrst_n_sync)
        ,.sleep_req        (sleep_req)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.rf_ready         (rf_ready)
    );

    // Write-side reset gates writes and seeds the array's own rclk reset
    rf_pg_16x35 #(
         .ECHO_DELAY (ECHO_DELAY)
    ) u_rf (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.rst_n            (wrst_n_sync)
        ,.wr               (wr)
        ,.rd               (rd)
        ,.rdata            (rdata)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
    );

endmodule

`default_nettype wire

//--- rf_macro/rf_array_2p.sv
// Behavioral 16x36 two-clock array macro with power gating, isolation and enable echo
`timescale 1ns/10ps
`default_nettype none

module rf_array_2p #(
     parameter int ECHO_DELAY = 2
) (
    // Write port
     input  logic                         wclk
    ,input  logic                         we
    ,input  logic [rf_pkg::RF_ADDR_W-1:0] waddr
    ,input  logic [rf_pkg::RF_PHYS_W-1:0] wdata

    // Read port
    ,input  logic                         rclk
    ,input  logic                         re
    ,input  logic [rf_pkg::RF_ADDR_W-1:0] raddr
    ,output logic [rf_pkg::RF_PHYS_W-1:0] rdata_out

    // Reset and power management
    ,input  logic                         ip_reset_b
    ,input  logic                         isol_en
    ,input  logic                         pwr_enable_b_in
    ,output logic                         pwr_enable_b_out
);

    import rf_pkg::*;

    // ------------------------------
    // Storage and power state
    // ------------------------------

    logic [RF_PHYS_W-1:0]  mem [RF_DEPTH];
    logic [RF_PHYS_W-1:0]  rd_q;
    logic [ECHO_DELAY-1:0] echo_q;
    logic                  powered;

    // The array counts as powered only once both the request and its echo are low
    assign powered = !pwr_enable_b_in && !pwr_enable_b_out;

    // Writes land on wclk and are dropped while the supply is gated
    always_ff @(posedge wclk) begin
        if (we && powered) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, the word appears one rclk after re is sampled
    // and holds until the next read
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            rd_q <= '0;
        end else if (re && powered) begin
            rd_q <= mem[raddr];
        end
    end

    // Isolation clamps the outputs low so a dark array never drives garbage
    assign rdata_out = isol_en ? '0 : rd_q;

    // ------------------------------
    // Power enable echo chain
    // ------------------------------

    // Models the daisy chain of power switches; out follows in after ECHO_DELAY rclk
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            echo_q <= '0;
        end else begin
            echo_q[0] <= pwr_enable_b_in;
            for (int i = 1; i < ECHO_DELAY; i++) begin
                echo_q[i] <= echo_q[i-1];
            end
        end
    end

    assign pwr_enable_b_out = echo_q[ECHO_DELAY-1];

endmodule

`default_nettype wire

//--- rf_macro/rf_pg_16x35.sv
// 16x35 register file wrapper around the 16x36 power-gated array macro
`timescale 1ns/10ps
`default_nettype none

module rf_pg_16x35 #(
     parameter int ECHO_DELAY = 2
) (
     input  logic                         wclk
    ,input  logic                         rclk
    ,input  logic                         rst_n

    // User side requests and read data
    ,input  rf_pkg::rf_wr_req_t           wr
    ,input  rf_pkg::rf_rd_req_t           rd
    ,output logic [rf_pkg::RF_DATA_W-1:0] rdata

    // Power interface from the sequencer
    ,input  logic                         isol_en
    ,input  logic                         pwr_enable_b_in
    ,output logic                         pwr_enable_b_out

    // Scan reset bypass
    ,input  logic                         fscan_rstbypen
    ,input  logic                         fscan_byprst_b
);

    import rf_pkg::*;

    logic                 ip_reset_b_sync;
    logic                 we_gated;
    logic [RF_PHYS_W-1:0] wdata_phys;
    logic [RF_PHYS_W-1:0] rdata_phys;

    // The macro keeps its own read-side reset, released on rclk
    rf_reset_sync u_ip_reset_sync (
         .clk            (rclk)
        ,.rst_n          (rst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (ip_reset_b_sync)
    );

    // No write may reach the array while the write side is still in reset
    assign we_gated = wr.en && rst_n;

    // Spare top bit is padded with zero on the way in
    assign wdata_phys = {1'b0, wr.data};

    // ------------------------------
    // Array macro
    // ------------------------------

    // Repair, fuse, BIST and RAM-scan pins exist only on the vendor macro,
    // where they are held at their functional values
    rf_array_2p #(
         .ECHO_DELAY (ECHO_DELAY)
    ) u_array (
         .wclk             (wclk)
        ,.we               (we_gated)
        ,.waddr            (wr.addr)
        ,.wdata            (wdata_phys)
        ,.rclk             (rclk)
        ,.re               (rd.en)
        ,.raddr            (rd.addr)
        ,.rdata_out        (rdata_phys)
        ,.ip_reset_b       (ip_reset_b_sync)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Spare bit dropped on the way out
    assign rdata = rdata_phys[RF_DATA_W-1:0];

endmodule

`default_nettype wire

//--- tests/rf_subsys_properties.sv
// Concurrent checks on the sleep and wake order of the power sequencer, bound to it
`timescale 1ns/10ps
`default_nettype none

module rf_subsys_properties (
     input  logic rclk
    ,input  logic rst_n
    ,input  logic isol_en
    ,input  logic pwr_enable_b
    ,input  logic pwr_enable_b_out
    ,input  logic rf_ready
);

    // Failure tallies, summed so the testbench sees one number
    int unsigned pwr_fail_cnt  = 0;
    int unsigned rdy_fail_cnt  = 0;
    int unsigned isol_fail_cnt = 0;
    int unsigned fail_count;

    assign fail_count = pwr_fail_cnt + rdy_fail_cnt + isol_fail_cnt;

    // ------------------------------
    // Sequence order
    // ------------------------------

    // Power is only cut behind the isolation clamps
    pwr_behind_isol: assert property (
        @(posedge rclk) disable iff (!rst_n)
        $rose(pwr_enable_b) |-> isol_en
    ) else begin
        $error("pwr_enable_b rose while isol_en was low");
        pwr_fail_cnt++;
    end

    // A ready port is never clamped
    ready_unclamped: assert property (
        @(posedge rclk) disable iff (!rst_n)
        rf_ready |-> !isol_en
    ) else begin
        $error("rf_ready high while isol_en high");
        rdy_fail_cnt++;
    end

    // Clamps come off only once the whole switch chain reports power on
    isol_after_echo: assert property (
        @(posedge rclk) disable iff (!rst_n)
        $fell(isol_en) |-> !$past(pwr_enable_b_out)
    ) else begin
        $error("isol_en fell before pwr_enable_b_out went low");
        isol_fail_cnt++;
    end

endmodule

bind rf_power_ctrl rf_subsys_properties u_props (
     .rclk             (rclk)
    ,.rst_n            (rst_n)
    ,.isol_en          (isol_en)
    ,.pwr_enable_b     (pwr_enable_b)
    ,.pwr_enable_b_out (pwr_enable_b_out)
    ,.rf_ready         (rf_ready)
);

`default_nettype wire

//--- tests/tb_rf_subsys.sv
// Testbench for the register file subsystem with a stimulus table, checks and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_rf_subsys;

    import rf_pkg::*;

    // Sequencer timing of the DUT at its default parameters
    localparam int PG_DELAY   = 4;
    localparam int ECHO_DELAY = 2;

    typedef enum logic [1:0] {WRITE, READ, SLEEP, WAKE} op_t;

    // One table row where exp matters only for READ
    typedef struct packed {
        op_t                  op;
        logic [RF_ADDR_W-1:0] addr;
        logic [RF_DATA_W-1:0] data;
        logic [RF_DATA_W-1:0] exp;
    } stim_entry_t;

    logic                 wclk = 1'b0;
    logic                 rclk = 1'b0;
    logic                 rst_n;
    rf_wr_req_t           wr;
    rf_rd_req_t           rd;
    logic [RF_DATA_W-1:0] rdata;
    logic                 sleep_req;
    logic                 rf_ready;
    logic                 fscan_rstbypen;
    logic                 fscan_byprst_b;

    stim_entry_t          stim_q [$];
    logic [RF_DATA_W-1:0] ref_mem [RF_DEPTH];
    bit                   model_asleep;
    int                   seed;
    int                   timeout_limit;
    int                   cycle_cnt;
    int                   n_pass;
    int                   n_fail;

    // ------------------------------
    // Clocks, DUT and timeout
    // ------------------------------

    // wclk rises at 10, 30 and so on
    always begin
        #10 wclk = 1'b1;
        #10 wclk = 1'b0;
    end

    // rclk has the same period and rises 5 ns after wclk
    always begin
        #5  rclk = 1'b0;
        #10 rclk = 1'b1;
        #5;
    end

    rf_subsys_top dut0 (
         .wclk           (wclk)
        ,.rclk           (rclk)
        ,.rst_n          (rst_n)
        ,.wr             (wr)
        ,.rd             (rd)
        ,.rdata          (rdata)
        ,.sleep_req      (sleep_req)
        ,.rf_ready       (rf_ready)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
    );

    always @(posedge rclk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d rclk cycles", timeout_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------
    // Table building
    // ------------------------------

    function automatic logic [RF_DATA_W-1:0] rand_data();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[RF_DATA_W-1:0];
    endfunction

    // Writes to a gated array are dropped, so the reference array keeps its word
    task automatic add_write(input logic [RF_ADDR_W-1:0] a, input logic [RF_DATA_W-1:0] d);
        stim_entry_t e;
        e = '{op: WRITE, addr: a, data: d, exp: '0};
        stim_q.push_back(e);
        if (!model_asleep) begin
            ref_mem[a] = d;
        end
    endtask

    // Reads of an isolated array see the clamp and not the stored word
    task automatic add_read(input logic [RF_ADDR_W-1:0] a);
        stim_entry_t e;
        e = '{op: READ, addr: a, data: '0, exp: (model_asleep ? '0 : ref_mem[a])};
        stim_q.push_back(e);
    endtask

    // Contents do not survive a sleep, so later reads only target fresh writes
    task automatic add_power(input op_t op);
        stim_entry_t e;
        e = '{op: op, addr: '0, data: '0, exp: '0};
        stim_q.push_back(e);
        model_asleep = (op == SLEEP);
    endtask

    // ------------------------------
    // Entry execution
    // ------------------------------

    task automatic do_write(input stim_entry_t e);
        @(posedge wclk);
        wr.en   <= 1'b1;
        wr.addr <= e.addr;
        wr.data <= e.data;
        @(posedge wclk);
        wr.en <= 1'b0;
        // Keep the next read well clear of the write across the clock crossing
        repeat (3) @(posedge rclk);
    endtask

    task automatic do_read(input stim_entry_t e, output bit ok);
        ok = 1'b1;
        @(posedge rclk);
        rd.en   <= 1'b1;
        rd.addr <= e.addr;
        @(posedge rclk);
        rd.en <= 1'b0;
        @(negedge rclk);
        assert (rdata === e.exp) else begin
            $display("Error: rdata = 0x%h, expected 0x%h", rdata, e.exp);
            ok = 1'b0;
        end
        // No new read is sampled here, so the word has to hold
        repeat (3) @(negedge rclk);
        assert (rdata === e.exp) else begin
            $display("Error: rdata = 0x%h after hold, expected 0x%h", rdata, e.exp);
            ok = 1'b0;
        end
    endtask

    task automatic do_sleep(output bit ok);
        ok = 1'b1;
        @(posedge rclk);
        sleep_req <= 1'b1;
        @(negedge rclk);
        while (rf_ready !== 1'b0) begin
            @(negedge rclk);
        end
        // Isolation rises on the same edge that drops rf_ready
        assert (rdata === '0) else begin
            $display("Error: rdata = 0x%h while isolated, expected 0x0", rdata);
            ok = 1'b0;
        end
        // Power is cut PG_DELAY edges later and the echo then needs ECHO_DELAY more
        repeat (PG_DELAY + ECHO_DELAY + 2) @(negedge rclk);
    endtask

    task automatic do_wake(output bit ok);
        int waited;
        ok     = 1'b1;
        waited = 0;
        @(posedge rclk);
        sleep_req <= 1'b0;
        @(negedge rclk);
        while (rf_ready !== 1'b1) begin
            @(negedge rclk);
            waited++;
        end
        // Ready needs the echo, then one edge to drop isolation and one more for ready
        assert (waited >= ECHO_DELAY + 2) else begin
            $display("Wake reported ready after only %0d cycles, %s", waited,
                     "before the power enable echo could have returned");
            ok = 1'b0;
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        stim_entry_t e;
        bit          ok;
        seed           = 32'h7804_89dd;
        model_asleep   = 1'b0;
        cycle_cnt      = 0;
        n_pass         = 0;
        n_fail         = 0;
        rst_n          = 1'b0;
        wr             = '0;
        rd             = '0;
        sleep_req      = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;

        for (int a = 0; a < RF_DEPTH - 1; a++) begin
            add_write(RF_ADDR_W'(a), rand_data());
        end
        // Top entry carries all ones across every user bit
        add_write(RF_ADDR_W'(RF_DEPTH - 1), '1);
        for (int a = 0; a < RF_DEPTH; a++) begin
            add_read(RF_ADDR_W'(a));
        end
        add_write(4'h5, rand_data());
        add_read(4'h5);
        // Poke the dark array, then rewrite after wake
        add_power(SLEEP);
        add_read(4'h2);
        add_write(4'h3, rand_data());
        add_power(WAKE);
        add_write(4'h3, rand_data());
        add_read(4'h3);
        timeout_limit = stim_q.size() * 40;

        repeat (5) @(posedge wclk);
        rst_n <= 1'b1;
        // Both reset synchronizers need two edges of their own clock
        repeat (4) @(posedge rclk);
        @(negedge rclk);
        ok = 1'b1;
        assert (rf_ready === 1'b1) else begin
            $display("Error: rf_ready = 0x%h after reset, expected 0x1", rf_ready);
            ok = 1'b0;
        end
        assert (rdata === '0) else begin
            $display("Error: rdata = 0x%h after reset, expected 0x0", rdata);
            ok = 1'b0;
        end
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test reset : %s", ok ? "ok" : "FAILED");

        foreach (stim_q[i]) begin
            e = stim_q[i];
            ok = 1'b1;
            case (e.op)
                WRITE: do_write(e);
                READ:  do_read(e, ok);
                SLEEP: do_sleep(ok);
                WAKE:  do_wake(ok);
                default: ok = 1'b0;
            endcase
            if (ok) begin
                n_pass++;
            end else begin
                n_fail++;
            end
            $display("test %0d %s addr 0x%h : %s", i, e.op.name(), e.addr,
                     ok ? "ok" : "FAILED");
        end

        // The bound sequence checks keep their own tally
        ok = 1'b1;
        assert (dut0.u_pwr_ctrl.u_props.fail_count == 0) else begin
            $display("Power sequence checks failed %0d times",
                     dut0.u_pwr_ctrl.u_props.fail_count);
            ok = 1'b0;
        end
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test power sequence : %s", ok ? "ok" : "FAILED");

        $display("Summary: %0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
